/* rtl/lsu_pkg.sv */
package lsu_pkg;

    // Data and address width of the core.
    localparam int XLEN = 32;

    // RV32I major opcodes of the memory instructions.
    localparam logic [6:0] OPC_LOAD  = 7'b0000011;
    localparam logic [6:0] OPC_STORE = 7'b0100011;

    // funct3 encodings of loads.
    localparam logic [2:0] F3_LB  = 3'b000;
    localparam logic [2:0] F3_LH  = 3'b001;
    localparam logic [2:0] F3_LW  = 3'b010;
    localparam logic [2:0] F3_LBU = 3'b100;
    localparam logic [2:0] F3_LHU = 3'b101;

    // funct3 encodings of stores.
    localparam logic [2:0] F3_SB = 3'b000;
    localparam logic [2:0] F3_SH = 3'b001;
    localparam logic [2:0] F3_SW = 3'b010;

    // Word i of the data memory holds i plus this value after reset.
    localparam logic [XLEN-1:0] FILL_BASE = 32'hFFFF0000;

    // Memory opcodes seen by the stage.
    typedef enum logic [3:0] {
        OP_NONE,
        OP_LB,
        OP_LH,
        OP_LW,
        OP_LBU,
        OP_LHU,
        OP_SB,
        OP_SH,
        OP_SW
    } mem_op_e;

endpackage

/* rtl/mem_op_decode.sv */
module mem_op_decode (
    input  logic [lsu_pkg::XLEN-1:0] inst,
    output lsu_pkg::mem_op_e         op
);

    logic [6:0] opcode;
    logic [2:0] funct3;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];

    always_comb begin
        op = lsu_pkg::OP_NONE;
        if (opcode == lsu_pkg::OPC_LOAD) begin
            case (funct3)
                lsu_pkg::F3_LB:  op = lsu_pkg::OP_LB;
                lsu_pkg::F3_LH:  op = lsu_pkg::OP_LH;
                lsu_pkg::F3_LW:  op = lsu_pkg::OP_LW;
                lsu_pkg::F3_LBU: op = lsu_pkg::OP_LBU;
                lsu_pkg::F3_LHU: op = lsu_pkg::OP_LHU;
                default:         op = lsu_pkg::OP_NONE;
            endcase
        end else if (opcode == lsu_pkg::OPC_STORE) begin
            case (funct3)
                lsu_pkg::F3_SB: op = lsu_pkg::OP_SB;
                lsu_pkg::F3_SH: op = lsu_pkg::OP_SH;
                lsu_pkg::F3_SW: op = lsu_pkg::OP_SW;
                default:        op = lsu_pkg::OP_NONE;
            endcase
        end
    end

endmodule

/* rtl/store_align.sv */
module store_align (
    input  lsu_pkg::mem_op_e         op,
    input  logic [1:0]               addr_low,
    input  logic [lsu_pkg::XLEN-1:0] wdata,
    output logic [3:0]               byte_en,
    output logic [lsu_pkg::XLEN-1:0] lane_data
);

    // Narrow stores copy their data onto every lane so that the
    // enables alone pick the target bytes.
    always_comb begin
        byte_en   = 4'b0000;
        lane_data = wdata;
        case (op)
            lsu_pkg::OP_SB: begin
                byte_en   = 4'b0001 << addr_low;
                lane_data = {4{wdata[7:0]}};
            end
            lsu_pkg::OP_SH: begin
                byte_en   = addr_low[1] ? 4'b1100 : 4'b0011;
                lane_data = {2{wdata[15:0]}};
            end
            lsu_pkg::OP_SW: begin
                byte_en   = 4'b1111;
                lane_data = wdata;
            end
            default: begin
                byte_en   = 4'b0000;
                lane_data = wdata;
            end
        endcase
    end

endmodule

/* rtl/data_mem.sv */
module data_mem #(
    parameter int MEM_WORDS = 4096
) (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         rd_en,
    input  logic [$clog2(MEM_WORDS)-1:0] word_addr,
    input  logic [3:0]                   byte_en,
    input  logic [lsu_pkg::XLEN-1:0]     wr_data,
    output logic [lsu_pkg::XLEN-1:0]     rd_word
);

    logic [lsu_pkg::XLEN-1:0] mem [MEM_WORDS];

    // The reset fill gives every word a distinct, recognizable value.
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < MEM_WORDS; i++) begin
                mem[i] <= lsu_pkg::FILL_BASE + i;
            end
        end else begin
            for (int b = 0; b < 4; b++) begin
                if (byte_en[b]) begin
                    mem[word_addr][8*b +: 8] <= wr_data[8*b +: 8];
                end
            end
        end
    end

    // Read port returns the content from before any write in the same cycle.
    always_ff @(posedge clk) begin
        if (!reset && rd_en) begin
            rd_word <= mem[word_addr];
        end
    end

endmodule

/* rtl/load_extract.sv */
module load_extract (
    input  lsu_pkg::mem_op_e         op,
    input  logic [1:0]               addr_low,
    input  logic [lsu_pkg::XLEN-1:0] word,
    output logic [lsu_pkg::XLEN-1:0] data
);

    logic [7:0]  byte_sel;
    logic [15:0] half_sel;

    assign byte_sel = word[{addr_low, 3'b000} +: 8];
    assign half_sel = addr_low[1] ? word[31:16] : word[15:0];

    always_comb begin
        case (op)
            lsu_pkg::OP_LB: begin
                data = {{24{byte_sel[7]}}, byte_sel};
            end
            lsu_pkg::OP_LH: begin
                data = {{16{half_sel[15]}}, half_sel};
            end
            lsu_pkg::OP_LBU: begin
                data = {24'd0, byte_sel};
            end
            lsu_pkg::OP_LHU: begin
                data = {16'd0, half_sel};
            end
            default: begin
                // LW and anything else take the whole word.
                data = word;
            end
        endcase
    end

endmodule

/* rtl/mem_stage.sv */
module mem_stage #(
    parameter int MEM_WORDS = 4096,
    parameter int RSP_DEPTH = 4
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     req_valid,
    input  logic [lsu_pkg::XLEN-1:0] req_inst,
    input  logic [lsu_pkg::XLEN-1:0] req_addr,
    input  logic [lsu_pkg::XLEN-1:0] req_wdata,
    output logic                     req_credit,
    input  logic                     rsp_credit,
    output logic                     rsp_valid,
    output logic [lsu_pkg::XLEN-1:0] rsp_data
);

    localparam int AW     = $clog2(MEM_WORDS);
    localparam int PTR_W  = (RSP_DEPTH > 1) ? $clog2(RSP_DEPTH) : 1;
    localparam int CNT_W  = $clog2(RSP_DEPTH + 1);
    localparam int CRED_W = 16;

    lsu_pkg::mem_op_e         dec_op;
    lsu_pkg::mem_op_e         op;
    logic                     is_load;
    logic                     is_other;
    logic [3:0]               byte_en;
    logic [lsu_pkg::XLEN-1:0] lane_data;
    logic [lsu_pkg::XLEN-1:0] rd_word;
    logic [lsu_pkg::XLEN-1:0] ld_data;

    // Stage-2 registers.
    logic                     s2_load;
    logic                     s2_other;
    lsu_pkg::mem_op_e         s2_op;
    logic [1:0]               s2_addr_low;

    logic [lsu_pkg::XLEN-1:0] q_data [RSP_DEPTH];
    logic [PTR_W-1:0]         q_wr_ptr;
    logic [PTR_W-1:0]         q_rd_ptr;
    logic [CNT_W-1:0]         q_count;
    logic [CRED_W-1:0]        rsp_cred;
    logic [CNT_W-1:0]         ret_pend;
    logic [CNT_W:0]           ret_total;

    mem_op_decode u_decode (
        .inst (req_inst),
        .op   (dec_op)
    );

    assign op       = req_valid ? dec_op : lsu_pkg::OP_NONE;
    assign is_load  = (op == lsu_pkg::OP_LB) || (op == lsu_pkg::OP_LH) ||
                      (op == lsu_pkg::OP_LW) || (op == lsu_pkg::OP_LBU) ||
                      (op == lsu_pkg::OP_LHU);
    assign is_other = req_valid && !is_load;

    store_align u_store (
        .op        (op),
        .addr_low  (req_addr[1:0]),
        .wdata     (req_wdata),
        .byte_en   (byte_en),
        .lane_data (lane_data)
    );

    data_mem #(
        .MEM_WORDS (MEM_WORDS)
    ) u_mem (
        .clk       (clk),
        .reset     (reset),
        .rd_en     (is_load),
        .word_addr (req_addr[AW+1:2]),
        .byte_en   (byte_en),
        .wr_data   (lane_data),
        .rd_word   (rd_word)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            s2_load  <= 1'b0;
            s2_other <= 1'b0;
        end else begin
            s2_load  <= is_load;
            s2_other <= is_other;
        end
    end

    always_ff @(posedge clk) begin
        s2_op       <= op;
        s2_addr_low <= req_addr[1:0];
    end

    load_extract u_load (
        .op       (s2_op),
        .addr_low (s2_addr_low),
        .word     (rd_word),
        .data     (ld_data)
    );

    // In-flight requests never exceed RSP_DEPTH, so the queue cannot overflow.
    assign rsp_valid = (q_count != '0) && (rsp_cred != '0);
    assign rsp_data  = q_data[q_rd_ptr];

    always_ff @(posedge clk) begin
        if (s2_load) begin
            q_data[q_wr_ptr] <= ld_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            q_wr_ptr <= '0;
            q_rd_ptr <= '0;
            q_count  <= '0;
            rsp_cred <= '0;
        end else begin
            if (s2_load) begin
                q_wr_ptr <= (q_wr_ptr == PTR_W'(RSP_DEPTH - 1)) ? '0 : q_wr_ptr + 1'b1;
            end
            if (rsp_valid) begin
                q_rd_ptr <= (q_rd_ptr == PTR_W'(RSP_DEPTH - 1)) ? '0 : q_rd_ptr + 1'b1;
            end
            q_count  <= q_count + CNT_W'(s2_load) - CNT_W'(rsp_valid);
            rsp_cred <= rsp_cred + CRED_W'(rsp_credit) - CRED_W'(rsp_valid);
        end
    end

    // A load response and a store retiring together owe two credits. Only one
    // goes out per cycle and the rest wait in ret_pend.
    assign ret_total  = {1'b0, ret_pend} + (CNT_W + 1)'(rsp_valid) + (CNT_W + 1)'(s2_other);
    assign req_credit = (ret_total != '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            ret_pend <= '0;
        end else begin
            ret_pend <= CNT_W'(ret_total - (CNT_W + 1)'(req_credit));
        end
    end

endmodule

/* testbench/mem_stage_asserts.sv */
module mem_stage_asserts #(
    parameter int RSP_DEPTH = 4
) (
    input logic        clk,
    input logic        reset,
    input logic        req_valid,
    input logic        req_credit,
    input logic        rsp_credit,
    input logic        rsp_valid,
    input logic [31:0] rsp_data
);

    // Response credits held by the stage, and requests not yet retired.
    int rsp_cred_cnt;
    int in_flight;

    // Number of assertion failures seen so far.
    int fail_count = 0;

    always_ff @(posedge clk) begin
        if (reset) begin
            rsp_cred_cnt <= 0;
            in_flight    <= 0;
        end else begin
            rsp_cred_cnt <= rsp_cred_cnt + int'(rsp_credit) - int'(rsp_valid);
            in_flight    <= in_flight + int'(req_valid) - int'(req_credit);
        end
    end

    quiet_in_reset: assert property (@(posedge clk)
        reset && $past(reset) |-> !rsp_valid && !req_credit)
        else begin
            fail_count++;
            $error("rsp_valid or req_credit high during reset");
        end

    rsp_needs_credit: assert property (@(posedge clk) disable iff (reset)
        rsp_valid |-> rsp_cred_cnt > 0)
        else begin
            fail_count++;
            $error("rsp_valid asserted with no response credit held");
        end

    rsp_data_known: assert property (@(posedge clk) disable iff (reset)
        rsp_valid |-> !$isunknown(rsp_data))
        else begin
            fail_count++;
            $error("rsp_data unknown while rsp_valid is high");
        end

    credit_bound: assert property (@(posedge clk) disable iff (reset)
        req_credit |-> in_flight > 0)
        else begin
            fail_count++;
            $error("request credit returned with no request outstanding");
        end

endmodule

bind mem_stage mem_stage_asserts #(
    .RSP_DEPTH (RSP_DEPTH)
) u_asserts (
    .clk        (clk),
    .reset      (reset),
    .req_valid  (req_valid),
    .req_credit (req_credit),
    .rsp_credit (rsp_credit),
    .rsp_valid  (rsp_valid),
    .rsp_data   (rsp_data)
);

/* testbench/tb_mem_stage.sv */
module tb_mem_stage;

    localparam int MEM_WORDS      = 256;
    localparam int RSP_DEPTH      = 4;
    localparam int NUM_REQS       = 600;
    localparam int DRAIN_CYCLES   = 200;
    localparam int TIMEOUT_CYCLES = NUM_REQS * 20 + 200;
    localparam logic [31:0] SEED      = 32'hcb22_74cf;
    localparam logic [31:0] FILL      = 32'hffff_0000;
    localparam logic [6:0]  LOAD_OPC  = 7'b0000011;
    localparam logic [6:0]  STORE_OPC = 7'b0100011;

    logic        clk;
    logic        reset;
    logic        req_valid;
    logic [31:0] req_inst;
    logic [31:0] req_addr;
    logic [31:0] req_wdata;
    logic        req_credit;
    logic        rsp_credit;
    logic        rsp_valid;
    logic [31:0] rsp_data;

    // Kinds 0 to 4 are loads, 5 to 7 stores, 8 a bad funct3 and 9 a non-memory op.
    string       kind_names [10] = '{"LB", "LH", "LW", "LBU", "LHU",
                                     "SB", "SH", "SW", "BAD", "ALU"};
    logic [2:0]  f3_table [8] = '{3'b000, 3'b001, 3'b010, 3'b100, 3'b101,
                                  3'b000, 3'b001, 3'b010};

    logic [31:0] model [MEM_WORDS];
    logic [31:0] exp_q [$];
    string       name_q [$];
    int          req_credits = RSP_DEPTH;
    int          issued = 0;
    int          grant_count = 0;
    int          rsp_count = 0;
    int          pause_left = 0;
    int          drain_left = DRAIN_CYCLES;
    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;
    int          kind;
    logic [31:0] addr;
    logic [31:0] data;

    mem_stage #(
        .MEM_WORDS (MEM_WORDS),
        .RSP_DEPTH (RSP_DEPTH)
    ) u_dut (
        .clk        (clk),
        .reset      (reset),
        .req_valid  (req_valid),
        .req_inst   (req_inst),
        .req_addr   (req_addr),
        .req_wdata  (req_wdata),
        .req_credit (req_credit),
        .rsp_credit (rsp_credit),
        .rsp_valid  (rsp_valid),
        .rsp_data   (rsp_data)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, %0d of %0d requests issued, %0d errors",
                     cycles, issued, NUM_REQS, errors);
            $display("TB FAILED");
            $finish;
        end
    end

    function automatic int word_index(logic [31:0] a);
        return int'((a >> 2) % MEM_WORDS);
    endfunction

    function automatic logic [31:0] build_inst(int k);
        logic [31:0] inst;
        inst = $urandom;
        if (k < 8) begin
            inst[6:0]   = (k < 5) ? LOAD_OPC : STORE_OPC;
            inst[14:12] = f3_table[k];
        end else if (k == 8) begin
            inst[6:0]   = ($urandom % 2 == 0) ? LOAD_OPC : STORE_OPC;
            inst[14]    = ($urandom % 2 == 0);
            inst[13:12] = 2'b11;
        end else if (inst[6:0] == LOAD_OPC || inst[6:0] == STORE_OPC) begin
            inst[4] = 1'b1;
        end
        return inst;
    endfunction

    function automatic logic [31:0] load_value(int k, logic [31:0] a);
        logic [31:0] w;
        logic [7:0]  b;
        logic [15:0] h;
        w = model[word_index(a)];
        b = w[8*a[1:0] +: 8];
        h = a[1] ? w[31:16] : w[15:0];
        case (k)
            0:       return {{24{b[7]}}, b};
            1:       return {{16{h[15]}}, h};
            3:       return {24'h0, b};
            4:       return {16'h0, h};
            default: return w;
        endcase
    endfunction

    task automatic apply_store(int k, logic [31:0] a, logic [31:0] d);
        int idx;
        idx = word_index(a);
        case (k)
            5:       model[idx][8*a[1:0] +: 8] = d[7:0];
            6:       model[idx][16*a[1] +: 16] = d[15:0];
            default: model[idx] = d;
        endcase
    endtask

    // Outputs are read at the edge, before the DUT registers move.
    task automatic sample_outputs();
        logic [31:0] exp;
        string       name;
        if (rsp_valid === 1'b1) begin
            rsp_count++;
            assert (rsp_count <= grant_count) else begin
                errors++;
                $display("Response sent without a granted response credit");
            end
            assert (exp_q.size() != 0) else begin
                errors++;
                $display("Response %h arrived with no load outstanding", rsp_data);
            end
            if (exp_q.size() != 0) begin
                exp  = exp_q.pop_front();
                name = name_q.pop_front();
                checks++;
                assert (rsp_data === exp) else begin
                    errors++;
                    $display("FAILED %s expected %h actual %h", name, exp, rsp_data);
                end
            end
        end
        if (req_credit === 1'b1) begin
            req_credits++;
        end
        assert (req_credits <= RSP_DEPTH) else begin
            errors++;
            $display("More request credits came back than requests were sent");
        end
    endtask

    initial begin
        void'($urandom(SEED));
        clk        = 1'b0;
        reset      = 1'b1;
        req_valid  = 1'b0;
        req_inst   = '0;
        req_addr   = '0;
        req_wdata  = '0;
        rsp_credit = 1'b0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            model[i] = FILL + i;
        end
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        while (issued < NUM_REQS ||
               (drain_left > 0 && (exp_q.size() != 0 || req_credits != RSP_DEPTH))) begin
            @(posedge clk);
            sample_outputs();
            if (issued == NUM_REQS) begin
                drain_left--;
            end
            req_valid  <= 1'b0;
            rsp_credit <= 1'b0;
            if (issued < NUM_REQS && req_credits > 0 && $urandom % 4 != 0) begin
                kind = $urandom % 10;
                addr = ($urandom % 2 == 0) ? ($urandom % 64) : $urandom;
                data = $urandom;
                req_valid <= 1'b1;
                req_inst  <= build_inst(kind);
                req_addr  <= addr;
                req_wdata <= data;
                req_credits--;
                issued++;
                if (kind < 5) begin
                    exp_q.push_back(load_value(kind, addr));
                    name_q.push_back($sformatf("%s addr %h", kind_names[kind], addr));
                end else if (kind < 8) begin
                    apply_store(kind, addr, data);
                end
            end
            // The consumer grants in advance, but stalls now and then for a while.
            if (pause_left > 0) begin
                pause_left--;
            end else if ($urandom % 40 == 0) begin
                pause_left = 20 + $urandom % 60;
            end else if (grant_count - rsp_count < 8 && $urandom % 2 == 0) begin
                rsp_credit <= 1'b1;
                grant_count++;
            end
        end
        repeat (10) begin
            @(posedge clk);
            sample_outputs();
            rsp_credit <= 1'b0;
        end
        assert (req_credits == RSP_DEPTH) else begin
            errors++;
            $display("FAILED credit return expected %0d actual %0d", RSP_DEPTH, req_credits);
        end
        assert (exp_q.size() == 0) else begin
            errors++;
            $display("%0d load responses never arrived", exp_q.size());
        end
        assert (u_dut.u_asserts.fail_count == 0) else begin
            errors++;
            $display("Protocol assertions on the DUT failed %0d times",
                     u_dut.u_asserts.fail_count);
        end
        $display("Checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

/* vlog.f */
rtl/lsu_pkg.sv
rtl/mem_op_decode.sv
rtl/store_align.sv
rtl/data_mem.sv
rtl/load_extract.sv
rtl/mem_stage.sv
testbench/mem_stage_asserts.sv
testbench/tb_mem_stage.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_mem_stage
FILELIST  = vlog.f
BUILD_DIR = obj_dir
LOG       = sim.log
SIMFLAGS  = +verilator+error+limit+1000

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) $(SIMFLAGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q -e "TB FAILED" -e "%Error" $(LOG) || ! grep -q "TB PASSED" $(LOG); then \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
